/* hw/vec_ctrl_defs.svh */
// Sizing and CSR map of the vector controller
// VEC_VL_W must hold vlmax for e8 at LMUL 8, which is VEC_VLENB * 8
// VEC_ELEN is also the width of rs1 and of the write-back data
`ifndef VEC_CTRL_DEFS_SVH
`define VEC_CTRL_DEFS_SVH

// Vector register geometry
`define VEC_VLEN  256
`define VEC_VLENB (`VEC_VLEN / 8)
`define VEC_ELEN  32

// Width of vl and vstart
`define VEC_VL_W 9

// Vector CSR addresses
`define VEC_CSR_VSTART 12'h008
`define VEC_CSR_VL     12'hC20
`define VEC_CSR_VTYPE  12'hC21
`define VEC_CSR_VLENB  12'hC22

// Instruction id from the core
`define VEC_ID_W 4

`endif

/* hw/vec_ctrl_pkg.sv */
// Types shared by the vector controller and its testbench
// LMUL uses the signed RVV encoding, so fractional values are negative
// EW_64 exists only so that the core can request it and see it rejected
`default_nettype none

`include "vec_ctrl_defs.svh"

package vec_ctrl_pkg;

  // Instruction kind as decoded by the core
  typedef enum logic [1:0] {
    OP_VCFG,
    OP_VCSR,
    OP_VEC
  } vec_op_e;

  // Target unit, UNIT_CON stays in the controller
  typedef enum logic [1:0] {
    UNIT_CON,
    UNIT_VFU,
    UNIT_VLSU,
    UNIT_VSLDU
  } vec_unit_e;

  typedef enum logic [1:0] {
    CSR_READ,
    CSR_WRITE,
    CSR_SET,
    CSR_CLEAR
  } vec_csr_op_e;

  typedef enum logic [2:0] {
    EW_8  = 3'd0,
    EW_16 = 3'd1,
    EW_32 = 3'd2,
    EW_64 = 3'd3
  } vec_vsew_e;

  typedef enum logic [2:0] {
    LMUL_1   = 3'd0,
    LMUL_2   = 3'd1,
    LMUL_4   = 3'd2,
    LMUL_8   = 3'd3,
    LMUL_RES = 3'd4,
    LMUL_F8  = 3'd5,
    LMUL_F4  = 3'd6,
    LMUL_F2  = 3'd7
  } vec_vlmul_e;

  typedef struct packed {
    logic       vill;
    vec_vsew_e  vsew;
    vec_vlmul_e vlmul;
  } vec_vtype_t;

  typedef logic [`VEC_VL_W-1:0] vec_vl_t;
  typedef logic [`VEC_ELEN-1:0] vec_data_t;

  // Decoded instruction as handed over by the core
  typedef struct packed {
    vec_op_e              op;
    vec_unit_e            unit;
    vec_csr_op_e          csr_op;
    logic [11:0]          csr_addr;
    vec_data_t            rs1;
    vec_vtype_t           vtype;
    logic                 keep_vl;
    logic [4:0]           rd;
    logic                 use_rd;
    logic [`VEC_ID_W-1:0] id;
  } vec_req_t;

  // Value of vtype after reset or a rejected configuration
  localparam vec_vtype_t VTYPE_ILLEGAL = '{vill: 1'b1, vsew: EW_8, vlmul: LMUL_1};

endpackage

`default_nettype wire

/* hw/vec_ctrl_if.sv */
// Internal links of the vector controller
// vec_issue_if valid is a one-cycle strobe per dispatched instruction,
// sinks cannot stall it
`timescale 1ns/10ps
`default_nettype none

// Instruction leaving the issue buffer
interface vec_issue_if
  import vec_ctrl_pkg::*;
();

  logic     valid;
  vec_req_t req;
  // Configuration changes LMUL against the current vtype
  logic     vlmul_change;

  modport issue (output valid, req, vlmul_change);
  modport sink  (input  valid, req, vlmul_change);

endinterface

// Architectural vector CSR state
interface vec_csr_if
  import vec_ctrl_pkg::*;
();

  vec_vtype_t vtype;
  vec_vl_t    vl;
  vec_vl_t    vstart;
  // vl that the configuration now on the dispatch link produces
  vec_vl_t    cfg_vl;

  modport csr  (output vtype, vl, vstart, cfg_vl);
  modport user (input  vtype, vl, vstart, cfg_vl);

endinterface

`default_nettype wire

/* hw/vec_csr_unit.sv */
// vstart, vl and vtype registers of the vector controller
// All updates happen at the edge that ends a dispatch cycle
// Only rs1 is used as the AVL, vlmax tops out at VEC_VLENB * 8
`timescale 1ns/10ps
`default_nettype none

`include "vec_ctrl_defs.svh"

module vec_csr_unit
  import vec_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  vec_issue_if.sink disp_if,
  vec_csr_if.csr    csr_if
);

  // SEW may exceed 8 by this many doublings at LMUL 1
  localparam logic signed [3:0] LmulSlack = 4'($clog2(`VEC_ELEN) - 3);

  vec_vtype_t vtype_q;
  vec_vl_t    vl_q;
  vec_vl_t    vstart_q;

  vec_req_t   req;
  vec_vtype_t cfg_vtype;
  vec_vl_t    cfg_vl;
  vec_vl_t    vlmax;
  logic       vtype_legal;
  logic       ratio_kept;

  // Sign extended log2 of LMUL
  function automatic logic signed [3:0] lmul_log2(vec_vlmul_e lmul);
    lmul_log2 = $signed({lmul[2], lmul});
  endfunction

  function automatic logic signed [3:0] sew_log2(vec_vsew_e sew);
    sew_log2 = $signed({1'b0, sew});
  endfunction

  assign req = disp_if.req;

  ////////////////////////////////
  // Configuration
  ////////////////////////////////

  always_comb begin
    vtype_legal = (req.vtype.vsew <= EW_32) &&
                  !(req.vtype.vlmul inside {LMUL_RES, LMUL_F8}) &&
                  (sew_log2(req.vtype.vsew) <= lmul_log2(req.vtype.vlmul) + LmulSlack);

    // Without an LMUL change the ratio holds only if SEW holds too
    if (disp_if.vlmul_change) begin
      ratio_kept = (sew_log2(req.vtype.vsew) - sew_log2(vtype_q.vsew)) ==
                   (lmul_log2(req.vtype.vlmul) - lmul_log2(vtype_q.vlmul));
    end else begin
      ratio_kept = (req.vtype.vsew == vtype_q.vsew);
    end

    vlmax = vec_vl_t'(`VEC_VLENB) >> req.vtype.vsew;
    case (req.vtype.vlmul)
      LMUL_F4: vlmax = vlmax >> 2;
      LMUL_F2: vlmax = vlmax >> 1;
      LMUL_2:  vlmax = vlmax << 1;
      LMUL_4:  vlmax = vlmax << 2;
      LMUL_8:  vlmax = vlmax << 3;
      default: vlmax = vlmax;
    endcase

    cfg_vtype = VTYPE_ILLEGAL;
    cfg_vl    = '0;
    if (vtype_legal && (!req.keep_vl || ratio_kept)) begin
      cfg_vtype      = req.vtype;
      cfg_vtype.vill = 1'b0;
      if (req.keep_vl) begin
        cfg_vl = vl_q;
      end else if (&req.rs1) begin
        // AVL of all ones asks for vlmax
        cfg_vl = vlmax;
      end else if (req.rs1 < vec_data_t'(vlmax)) begin
        cfg_vl = vec_vl_t'(req.rs1);
      end else begin
        cfg_vl = vlmax;
      end
    end
  end

  ////////////////////////////////
  // Registers
  ////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vtype_q  <= VTYPE_ILLEGAL;
      vl_q     <= '0;
      vstart_q <= '0;
    end else if (disp_if.valid) begin
      case (req.op)
        OP_VEC: vstart_q <= '0;
        OP_VCFG: begin
          vtype_q <= cfg_vtype;
          vl_q    <= cfg_vl;
        end
        OP_VCSR: begin
          if (req.csr_addr == `VEC_CSR_VSTART) begin
            case (req.csr_op)
              CSR_WRITE: vstart_q <= vec_vl_t'(req.rs1);
              CSR_SET:   vstart_q <= vstart_q | vec_vl_t'(req.rs1);
              CSR_CLEAR: vstart_q <= vstart_q & ~vec_vl_t'(req.rs1);
              default:   vstart_q <= vstart_q;
            endcase
          end
        end
        default: vstart_q <= vstart_q;
      endcase
    end
  end

  assign csr_if.vtype  = vtype_q;
  assign csr_if.vl     = vl_q;
  assign csr_if.vstart = vstart_q;
  assign csr_if.cfg_vl = cfg_vl;

endmodule

`default_nettype wire

/* hw/vec_issue_stage.sv */
// One-entry issue buffer between the core and the vector units
// Ready is high only with an empty buffer, so there is no fall-through
// A buffered instruction leaves only when none of the stalls hold
`timescale 1ns/10ps
`default_nettype none

`include "vec_ctrl_defs.svh"

module vec_issue_stage
  import vec_ctrl_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 in_valid_i,
  input  vec_req_t             in_req_i,
  output logic                 in_ready_o,
  output logic                 in_accept_o,
  input  logic                 vfu_ready_i,
  input  logic                 vlsu_ready_i,
  input  logic                 vsldu_ready_i,
  vec_csr_if.user              csr_if,
  vec_issue_if.issue           disp_if,
  output logic                 unit_req_valid_o,
  output vec_unit_e            unit_req_unit_o,
  output vec_vl_t              unit_req_vl_o,
  output vec_vl_t              unit_req_vstart_o,
  output vec_vtype_t           unit_req_vtype_o,
  output logic [`VEC_ID_W-1:0] unit_req_id_o
);

  logic     buf_valid_q;
  vec_req_t buf_req_q;
  vec_req_t disp_req;

  logic push;
  logic pop;
  logic any_busy;
  logic unit_stall;
  logic vstart_stall;
  logic vlmul_change;
  logic stall;

  ////////////////////////////////
  // Accept and buffer
  ////////////////////////////////

  assign in_ready_o = !buf_valid_q;

  // Vector work is refused while vtype is illegal
  assign in_accept_o = in_valid_i && in_ready_o &&
                       !((in_req_i.op == OP_VEC) && csr_if.vtype.vill);
  assign push = in_accept_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      buf_valid_q <= 1'b0;
    end else if (push) begin
      buf_valid_q <= 1'b1;
    end else if (pop) begin
      buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_req_q <= in_req_i;
    end
  end

  ////////////////////////////////
  // Stalls
  ////////////////////////////////

  assign any_busy = !vfu_ready_i || !vlsu_ready_i || !vsldu_ready_i;

  always_comb begin
    unit_stall = 1'b0;
    if (buf_req_q.op == OP_VEC) begin
      case (buf_req_q.unit)
        UNIT_VFU:   unit_stall = !vfu_ready_i;
        UNIT_VLSU:  unit_stall = !vlsu_ready_i;
        UNIT_VSLDU: unit_stall = !vsldu_ready_i;
        default:    unit_stall = 1'b0;
      endcase
    end
  end

  assign vstart_stall = (csr_if.vstart != '0) && any_busy;
  // LMUL may only change once all units have drained
  assign vlmul_change = (buf_req_q.op == OP_VCFG) &&
                        (buf_req_q.vtype.vlmul != csr_if.vtype.vlmul);
  assign stall = unit_stall || vstart_stall || (vlmul_change && any_busy);
  assign pop   = buf_valid_q && !stall;

  ////////////////////////////////
  // Dispatch
  ////////////////////////////////

  // VLSU keeps the element width of its own request
  always_comb begin
    disp_req = buf_req_q;
    if ((buf_req_q.op == OP_VEC) && (buf_req_q.unit != UNIT_VLSU)) begin
      disp_req.vtype = csr_if.vtype;
    end
  end

  assign disp_if.valid        = pop;
  assign disp_if.req          = disp_req;
  assign disp_if.vlmul_change = vlmul_change;

  assign unit_req_valid_o  = pop && (buf_req_q.op == OP_VEC);
  assign unit_req_unit_o   = disp_req.unit;
  assign unit_req_vl_o     = csr_if.vl;
  assign unit_req_vstart_o = csr_if.vstart;
  assign unit_req_vtype_o  = disp_req.vtype;
  assign unit_req_id_o     = disp_req.id;

endmodule

`default_nettype wire

/* hw/vec_retire_unit.sv */
// Write-back of configuration and CSR results to the core
// Results are a one-cycle strobe, the core cannot hold them off
// CSR reads see the value from before the same dispatch updates it
`timescale 1ns/10ps
`default_nettype none

`include "vec_ctrl_defs.svh"

module vec_retire_unit
  import vec_ctrl_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  vec_issue_if.sink            disp_if,
  vec_csr_if.user              csr_if,
  output logic                 result_valid_o,
  output logic [`VEC_ID_W-1:0] result_id_o,
  output logic [4:0]           result_rd_o,
  output vec_data_t            result_data_o
);

  vec_data_t data_d;

  always_comb begin
    data_d = '0;
    if (disp_if.req.op == OP_VCFG) begin
      data_d = vec_data_t'(csr_if.cfg_vl);
    end else if (disp_if.req.use_rd) begin
      // vtype reads back with vill in bit 6
      case (disp_if.req.csr_addr)
        `VEC_CSR_VSTART: data_d = vec_data_t'(csr_if.vstart);
        `VEC_CSR_VL:     data_d = vec_data_t'(csr_if.vl);
        `VEC_CSR_VTYPE:  data_d = vec_data_t'(csr_if.vtype);
        `VEC_CSR_VLENB:  data_d = vec_data_t'(`VEC_VLENB);
        default:         data_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= disp_if.valid && (disp_if.req.op != OP_VEC);
    end
  end

  always_ff @(posedge clk_i) begin
    if (disp_if.valid) begin
      result_id_o   <= disp_if.req.id;
      result_rd_o   <= disp_if.req.rd;
      result_data_o <= data_d;
    end
  end

endmodule

`default_nettype wire

/* hw/vec_ctrl_top.sv */
// Vector instruction controller beside a scalar core
// The core presents instructions already decoded into fields
// No register hazard tracking, units must order their own accesses
`timescale 1ns/10ps
`default_nettype none

`include "vec_ctrl_defs.svh"

module vec_ctrl_top
  import vec_ctrl_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  // Core issue port
  input  logic                 issue_valid_i,
  input  vec_op_e              issue_op_i,
  input  vec_unit_e            issue_unit_i,
  input  vec_csr_op_e          issue_csr_op_i,
  input  logic [11:0]          issue_csr_addr_i,
  input  vec_data_t            issue_rs1_i,
  input  vec_vtype_t           issue_vtype_i,
  input  logic                 issue_keep_vl_i,
  input  logic [4:0]           issue_rd_i,
  input  logic                 issue_use_rd_i,
  input  logic [`VEC_ID_W-1:0] issue_id_i,
  output logic                 issue_ready_o,
  output logic                 issue_accept_o,
  // Unit readiness
  input  logic                 vfu_ready_i,
  input  logic                 vlsu_ready_i,
  input  logic                 vsldu_ready_i,
  // Request to the units
  output logic                 unit_req_valid_o,
  output vec_unit_e            unit_req_unit_o,
  output vec_vl_t              unit_req_vl_o,
  output vec_vl_t              unit_req_vstart_o,
  output vec_vtype_t           unit_req_vtype_o,
  output logic [`VEC_ID_W-1:0] unit_req_id_o,
  // Write-back to the core
  output logic                 result_valid_o,
  output logic [`VEC_ID_W-1:0] result_id_o,
  output logic [4:0]           result_rd_o,
  output vec_data_t            result_data_o
);

  vec_req_t issue_req;

  vec_issue_if disp_if ();
  vec_csr_if   csr_if ();

  assign issue_req = '{op:       issue_op_i,
                       unit:     issue_unit_i,
                       csr_op:   issue_csr_op_i,
                       csr_addr: issue_csr_addr_i,
                       rs1:      issue_rs1_i,
                       vtype:    issue_vtype_i,
                       keep_vl:  issue_keep_vl_i,
                       rd:       issue_rd_i,
                       use_rd:   issue_use_rd_i,
                       id:       issue_id_i};

  vec_csr_unit u_csr (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .disp_if (disp_if),
    .csr_if  (csr_if)
  );

  vec_issue_stage u_issue (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .in_valid_i        (issue_valid_i),
    .in_req_i          (issue_req),
    .in_ready_o        (issue_ready_o),
    .in_accept_o       (issue_accept_o),
    .vfu_ready_i       (vfu_ready_i),
    .vlsu_ready_i      (vlsu_ready_i),
    .vsldu_ready_i     (vsldu_ready_i),
    .csr_if            (csr_if),
    .disp_if           (disp_if),
    .unit_req_valid_o  (unit_req_valid_o),
    .unit_req_unit_o   (unit_req_unit_o),
    .unit_req_vl_o     (unit_req_vl_o),
    .unit_req_vstart_o (unit_req_vstart_o),
    .unit_req_vtype_o  (unit_req_vtype_o),
    .unit_req_id_o     (unit_req_id_o)
  );

  vec_retire_unit u_retire (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .disp_if        (disp_if),
    .csr_if         (csr_if),
    .result_valid_o (result_valid_o),
    .result_id_o    (result_id_o),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o)
  );

endmodule

`default_nettype wire

/* tb/vec_ctrl_checker.sv */
// Concurrent checks on the issue handshake and unit dispatch
// Bound into vec_ctrl_top and sees only its ports
// fail_count is read by the testbench summary
`timescale 1ns/10ps
`default_nettype none

module vec_ctrl_checker
  import vec_ctrl_pkg::*;
(
  input logic      clk_i,
  input logic      reset_i,
  input logic      issue_accept_i,
  input logic      issue_ready_i,
  input logic      unit_req_valid_i,
  input vec_unit_e unit_req_unit_i,
  input logic      vfu_ready_i,
  input logic      vlsu_ready_i,
  input logic      vsldu_ready_i
);

  int   fail_count = 0;
  logic unit_ready;

  // Ready input of the unit that the request targets
  always_comb begin
    case (unit_req_unit_i)
      UNIT_VFU:   unit_ready = vfu_ready_i;
      UNIT_VLSU:  unit_ready = vlsu_ready_i;
      UNIT_VSLDU: unit_ready = vsldu_ready_i;
      default:    unit_ready = 1'b0;
    endcase
  end

  a_no_disp_in_reset: assert property (
    @(posedge clk_i) (reset_i && $past(reset_i)) |-> !unit_req_valid_i
  ) else begin
    fail_count++;
    $error("unit request raised during reset");
  end

  // An accepted instruction fills the only buffer entry
  a_accept_blocks_ready: assert property (
    @(posedge clk_i) disable iff (reset_i) issue_accept_i |=> !issue_ready_i
  ) else begin
    fail_count++;
    $error("issue_ready_o high right after an accepted instruction");
  end

  a_disp_unit_ready: assert property (
    @(posedge clk_i) disable iff (reset_i) unit_req_valid_i |-> unit_ready
  ) else begin
    fail_count++;
    $error("dispatch to a unit that is not ready");
  end

endmodule

bind vec_ctrl_top vec_ctrl_checker u_checker (
  .clk_i            (clk_i),
  .reset_i          (reset_i),
  .issue_accept_i   (issue_accept_o),
  .issue_ready_i    (issue_ready_o),
  .unit_req_valid_i (unit_req_valid_o),
  .unit_req_unit_i  (unit_req_unit_o),
  .vfu_ready_i      (vfu_ready_i),
  .vlsu_ready_i     (vlsu_ready_i),
  .vsldu_ready_i    (vsldu_ready_i)
);

`default_nettype wire

/* tb/vec_ctrl_tb.sv */
// Table driven testbench for the vector controller
// Entries are applied one at a time, each waits for its own result or dispatch
// Unit readiness is random only for entries added in the back-pressure phase
`timescale 1ns/10ps
`default_nettype none

`include "vec_ctrl_defs.svh"

module vec_ctrl_tb
  import vec_ctrl_pkg::*;
();

  localparam int TIMEOUT = 200;
  localparam vec_data_t ALL_ONES = '1;

  typedef struct packed {
    vec_op_e     op;
    vec_unit_e   unit;
    vec_csr_op_e csr_op;
    logic [11:0] csr_addr;
    vec_data_t   rs1;
    vec_vtype_t  vtype;
    logic        keep_vl;
    logic        exp_accept;
    vec_data_t   exp_data;
    vec_vl_t     exp_vl;
    vec_vl_t     exp_vstart;
    vec_vtype_t  exp_vtype;
    logic        busy;
  } stim_t;

  typedef struct packed {
    vec_unit_e            unit;
    vec_vl_t              vl;
    vec_vl_t              vstart;
    vec_vtype_t           vtype;
    logic [`VEC_ID_W-1:0] id;
  } disp_t;

  logic clk_i = 1'b0;
  logic reset_i;
  logic issue_valid_i;
  vec_op_e issue_op_i;
  vec_unit_e issue_unit_i;
  vec_csr_op_e issue_csr_op_i;
  logic [11:0] issue_csr_addr_i;
  vec_data_t issue_rs1_i;
  vec_vtype_t issue_vtype_i;
  logic issue_keep_vl_i;
  logic [4:0] issue_rd_i;
  logic issue_use_rd_i;
  logic [`VEC_ID_W-1:0] issue_id_i;
  logic vfu_ready_i;
  logic vlsu_ready_i;
  logic vsldu_ready_i;
  logic issue_ready_o;
  logic issue_accept_o;
  logic unit_req_valid_o;
  vec_unit_e unit_req_unit_o;
  vec_vl_t unit_req_vl_o;
  vec_vl_t unit_req_vstart_o;
  vec_vtype_t unit_req_vtype_o;
  logic [`VEC_ID_W-1:0] unit_req_id_o;
  logic result_valid_o;
  logic [`VEC_ID_W-1:0] result_id_o;
  logic [4:0] result_rd_o;
  vec_data_t result_data_o;

  stim_t       stim [$];
  disp_t       disp_q [$];
  logic        bp_phase = 1'b0;
  logic        rand_mode = 1'b0;
  logic        timed_out = 1'b0;
  logic [31:0] lfsr = 32'h661c;
  int          errors = 0;

  vec_ctrl_top u_vec_ctrl_top (.*);

  always #4 clk_i = ~clk_i;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  always @(posedge clk_i) begin
    #1;
    if (rand_mode) begin
      lfsr = lfsr_step(lfsr);
      vfu_ready_i = lfsr[0];
      lfsr = lfsr_step(lfsr);
      vlsu_ready_i = lfsr[0];
      lfsr = lfsr_step(lfsr);
      vsldu_ready_i = lfsr[0];
    end else begin
      {vfu_ready_i, vlsu_ready_i, vsldu_ready_i} = 3'b111;
    end
  end

  // Record every unit request in the middle of its cycle
  always @(negedge clk_i) begin
    if (!reset_i && unit_req_valid_o) begin
      disp_q.push_back('{unit_req_unit_o, unit_req_vl_o, unit_req_vstart_o, unit_req_vtype_o,
                         unit_req_id_o});
    end
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_result(input string what, input vec_data_t got, input vec_data_t exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %0b expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic check_id(input string what, input logic [`VEC_ID_W-1:0] got,
                          input logic [`VEC_ID_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_rd(input string what, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_dispatch(input disp_t got, input vec_unit_e unit, input vec_vl_t vl,
                                input vec_vl_t vstart, input vec_vtype_t vtype);
    if (got.unit !== unit) begin
      errors++;
      $display("[ERROR] %0t: dispatch unit got %s expected %s", $time, got.unit.name(),
               unit.name());
    end
    if (got.vl !== vl) begin
      errors++;
      $display("[ERROR] %0t: dispatch vl got %0d expected %0d", $time, got.vl, vl);
    end
    if (got.vstart !== vstart) begin
      errors++;
      $display("[ERROR] %0t: dispatch vstart got %0d expected %0d", $time, got.vstart, vstart);
    end
    if (got.vtype !== vtype) begin
      errors++;
      $display("[ERROR] %0t: dispatch vtype got %0h expected %0h", $time, got.vtype, vtype);
    end
  endtask

  //////////////////////////////
  // Table building
  //////////////////////////////

  function automatic vec_vtype_t make_vtype(input vec_vsew_e sew, input vec_vlmul_e lmul);
    make_vtype = '{vill: 1'b0, vsew: sew, vlmul: lmul};
  endfunction

  task automatic add_cfg(input vec_vtype_t vt, input vec_data_t rs1, input logic keep,
                         input vec_data_t exp_vl);
    stim.push_back('{OP_VCFG, UNIT_CON, CSR_READ, 12'h000, rs1, vt, keep, 1'b1, exp_vl,
                     '0, '0, '0, bp_phase});
  endtask

  task automatic add_csr(input vec_csr_op_e op, input logic [11:0] addr, input vec_data_t rs1,
                         input vec_data_t exp_data);
    stim.push_back('{OP_VCSR, UNIT_CON, op, addr, rs1, make_vtype(EW_8, LMUL_1), 1'b0, 1'b1,
                     exp_data, '0, '0, '0, bp_phase});
  endtask

  // Requests always carry e8 m1, exp_vt is the vtype the unit must see
  task automatic add_vec(input vec_unit_e unit, input logic accept, input vec_vl_t vl,
                         input vec_vl_t vstart, input vec_vtype_t exp_vt);
    stim.push_back('{OP_VEC, unit, CSR_READ, 12'h000, '0, make_vtype(EW_8, LMUL_1), 1'b0,
                     accept, '0, vl, vstart, exp_vt, bp_phase});
  endtask

  task automatic build_table();
    add_vec(UNIT_VFU, 1'b0, 0, 0, VTYPE_ILLEGAL);           // vill after reset
    add_cfg(make_vtype(EW_32, LMUL_1), ALL_ONES, 1'b0, 8);  // 32 >> 2
    add_cfg(make_vtype(EW_8, LMUL_2), 5, 1'b0, 5);          // vlmax 64
    add_cfg(make_vtype(EW_16, LMUL_4), 100, 1'b0, 64);      // clipped to vlmax
    add_cfg(make_vtype(EW_64, LMUL_1), ALL_ONES, 1'b0, 0);
    add_csr(CSR_READ, `VEC_CSR_VTYPE, 0, 32'h40);           // vill, e8, m1
    add_cfg(make_vtype(EW_8, LMUL_F8), 4, 1'b0, 0);
    add_vec(UNIT_VLSU, 1'b0, 0, 0, VTYPE_ILLEGAL);
    add_cfg(make_vtype(EW_32, LMUL_2), 10, 1'b0, 10);       // vlmax 16
    add_csr(CSR_READ, `VEC_CSR_VL, 0, 10);
    add_csr(CSR_READ, `VEC_CSR_VLENB, 0, `VEC_VLENB);
    add_csr(CSR_WRITE, `VEC_CSR_VSTART, 3, 0);
    add_csr(CSR_SET, `VEC_CSR_VSTART, 4, 3);
    add_csr(CSR_CLEAR, `VEC_CSR_VSTART, 1, 7);
    add_csr(CSR_READ, `VEC_CSR_VSTART, 0, 6);
    add_vec(UNIT_VFU, 1'b1, 10, 6, make_vtype(EW_32, LMUL_2));
    add_csr(CSR_READ, `VEC_CSR_VSTART, 0, 0);
    // Ratio 16 kept, then broken
    add_cfg(make_vtype(EW_16, LMUL_1), 0, 1'b1, 10);
    add_cfg(make_vtype(EW_8, LMUL_1), 0, 1'b1, 0);
    add_cfg(make_vtype(EW_16, LMUL_1), ALL_ONES, 1'b0, 16);
    bp_phase = 1'b1;
    add_vec(UNIT_VFU, 1'b1, 16, 0, make_vtype(EW_16, LMUL_1));
    add_vec(UNIT_VLSU, 1'b1, 16, 0, make_vtype(EW_8, LMUL_1));
    add_vec(UNIT_VSLDU, 1'b1, 16, 0, make_vtype(EW_16, LMUL_1));
    add_vec(UNIT_VFU, 1'b1, 16, 0, make_vtype(EW_16, LMUL_1));
    add_vec(UNIT_VLSU, 1'b1, 16, 0, make_vtype(EW_8, LMUL_1));
    add_cfg(make_vtype(EW_8, LMUL_2), 20, 1'b0, 20);        // LMUL change under load
    add_vec(UNIT_VSLDU, 1'b1, 20, 0, make_vtype(EW_8, LMUL_2));
    add_vec(UNIT_VFU, 1'b1, 20, 0, make_vtype(EW_8, LMUL_2));
    add_csr(CSR_READ, `VEC_CSR_VL, 0, 20);
  endtask

  //////////////////////////////
  // Waits
  //////////////////////////////

  task automatic wait_ready(input int idx, output logic ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < TIMEOUT && !ok; n++) begin
      @(negedge clk_i);
      ok = issue_ready_o;
    end
    if (!ok) begin
      $display("Timeout: issue_ready_o stayed low before entry %0d", idx);
    end
  endtask

  task automatic wait_result(input int idx, output logic ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < TIMEOUT && !ok; n++) begin
      @(negedge clk_i);
      ok = result_valid_o;
    end
    if (!ok) begin
      $display("Timeout: no result for entry %0d", idx);
    end
  endtask

  task automatic wait_dispatch(input int idx, output logic ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < TIMEOUT && !ok; n++) begin
      @(posedge clk_i);
      ok = (disp_q.size() != 0);
    end
    if (!ok) begin
      $display("Timeout: entry %0d was never dispatched", idx);
    end
  endtask

  task automatic apply_entry(input int idx);
    stim_t                e;
    disp_t                d;
    logic                 ok;
    logic                 got_accept;
    logic [`VEC_ID_W-1:0] id;
    logic [4:0]           rd;
    e  = stim[idx];
    id = idx[`VEC_ID_W-1:0];
    rd = idx[4:0];
    rand_mode = e.busy;
    wait_ready(idx, ok);
    if (!ok) begin
      timed_out = 1'b1;
    end else begin
      @(posedge clk_i);
      #1;
      issue_valid_i    = 1'b1;
      issue_op_i       = e.op;
      issue_unit_i     = e.unit;
      issue_csr_op_i   = e.csr_op;
      issue_csr_addr_i = e.csr_addr;
      issue_rs1_i      = e.rs1;
      issue_vtype_i    = e.vtype;
      issue_keep_vl_i  = e.keep_vl;
      issue_rd_i       = rd;
      issue_use_rd_i   = 1'b1;
      issue_id_i       = id;
      @(negedge clk_i);
      got_accept = issue_accept_o;
      check_flag("issue_accept_o", got_accept, e.exp_accept);
      @(posedge clk_i);
      #1;
      issue_valid_i = 1'b0;
      if (got_accept && (e.op == OP_VEC)) begin
        wait_dispatch(idx, ok);
        if (ok) begin
          d = disp_q.pop_front();
          check_dispatch(d, e.unit, e.exp_vl, e.exp_vstart, e.exp_vtype);
          check_id("dispatch id", d.id, id);
        end
      end else if (got_accept) begin
        wait_result(idx, ok);
        if (ok) begin
          check_result("result data", result_data_o, e.exp_data);
          check_id("result id", result_id_o, id);
          check_rd("result rd", result_rd_o, rd);
        end
      end
      if (!ok) begin
        timed_out = 1'b1;
      end
    end
  endtask

  initial begin
    int i;
    reset_i          = 1'b1;
    issue_valid_i    = 1'b0;
    issue_op_i       = OP_VCFG;
    issue_unit_i     = UNIT_CON;
    issue_csr_op_i   = CSR_READ;
    issue_csr_addr_i = '0;
    issue_rs1_i      = '0;
    issue_vtype_i    = '0;
    issue_keep_vl_i  = 1'b0;
    issue_rd_i       = '0;
    issue_use_rd_i   = 1'b0;
    issue_id_i       = '0;
    vfu_ready_i      = 1'b1;
    vlsu_ready_i     = 1'b1;
    vsldu_ready_i    = 1'b1;
    build_table();
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    for (i = 0; i < stim.size() && !timed_out; i++) begin
      apply_entry(i);
    end
    if (!timed_out && (disp_q.size() != 0)) begin
      errors++;
      $display("Unexpected dispatch of %0d instructions left over", disp_q.size());
    end
    $display("Summary: %0d value errors, %0d timeouts, %0d assertion failures",
             errors, timed_out, u_vec_ctrl_top.u_checker.fail_count);
    if ((errors == 0) && !timed_out && (u_vec_ctrl_top.u_checker.fail_count == 0)) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+hw
hw/vec_ctrl_pkg.sv
hw/vec_ctrl_if.sv
hw/vec_csr_unit.sv
hw/vec_issue_stage.sv
hw/vec_retire_unit.sv
hw/vec_ctrl_top.sv
tb/vec_ctrl_checker.sv
tb/vec_ctrl_tb.sv
